// File: sdhc_testdata.txt
# step codes: T name | W addr data | R addr expected | P present | E error pulse
# B block done | I irq level and pulse count since last I, all other values in hex
T reset_values
R 04 0000
R 06 0000
R 0C 0000
R 24 0000
R 30 0000
R 32 0000
R 34 0000
R 3A 0000
I 0 0
T write_readback
W 04 F200
R 04 0200
W 06 0003
R 06 0003
W 0C 00FF
R 0C 0037
W 34 FFFF
R 34 00F3
W 36 00FF
R 36 00FF
T inhibit_gating
P 01
W 0C 0000
R 0C 0037
R 24 0001
P 02
W 04 0100
W 06 0009
R 04 0200
R 06 0003
R 24 0002
P 00
R 30 0003
W 30 0003
R 30 0000
T present_edges
P 1C
R 24 8C00
R 30 0070
P 00
R 30 00F0
W 30 0050
R 30 00A0
W 30 00A0
R 30 0000
T edges_masked
W 34 0000
P 1C
P 00
P 01
P 00
R 30 0000
T error_status
W 36 000F
E 81
R 32 0001
R 30 8000
E 82
R 32 0003
W 32 0003
R 32 0000
R 30 0000
T irq_generation
W 34 00F3
W 38 0001
I 0 0
P 01
P 00
I 1 1
W 3A 0001
E 01
I 1 0
W 30 0001
I 1 0
W 32 0001
I 0 0
T block_count
W 06 0002
B
R 06 0001
B
R 06 0000
B
R 06 0000
W 0C 0000
W 06 0005
B
R 06 0005

// File: sim.f
+incdir+.
sdhc_pkg.sv
sdhc_block_counter.sv
sdhc_regs.sv
sdhc_reg_logic.sv
sdhc_top.sv
sdhc_sva.sv
tb_sdhc.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdhc
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_sdhc.sv
`timescale 1ns/1ps
// testbench for the SD host register block
// replays the step file and checks read data and interrupts

`include "sdhc_settings.svh"

module tb_sdhc import sdhc_pkg::*; ();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_STEP = 20;

  logic                clk;
  logic                rst_n;
  sdhc_bus_wr_t        wr;
  sdhc_addr_e          rd_addr;
  logic [`SDHC_DW-1:0] rdata;
  sdhc_present_t       present;
  logic [7:0]          err_event;
  logic                block_done;
  logic                irq;
  logic                irq_pulse;

  logic [7:0]      step_code[$];
  logic [31:0]     step_a[$];
  logic [31:0]     step_b[$];
  logic [8*24-1:0] step_name[$];

  logic [8*24-1:0] cur_name;
  int  cur_errors  = 0;
  bit  test_active = 0;
  int  test_count  = 0;
  int  fail_count  = 0;
  int  check_count = 0;
  int  error_count = 0;
  int  pulse_total = 0;
  int  pulse_mark  = 0;
  int  cycles      = 0;
  int  cycle_limit = 0;

  sdhc_top i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .wr_i         (wr),
    .rd_addr_i    (rd_addr),
    .rdata_o      (rdata),
    .present_i    (present),
    .err_event_i  (err_event),
    .block_done_i (block_done),
    .irq_o        (irq),
    .irq_pulse_o  (irq_pulse)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // pulse is stable across the falling edge
  always @(negedge clk) begin
    if (rst_n && irq_pulse) begin
      pulse_total++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the step list did not finish", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic load_steps(input int fd);
    logic [8*24-1:0]  tok;
    logic [8*24-1:0]  name;
    logic [8*120-1:0] rest;
    logic [31:0]      a;
    logic [31:0]      b;
    int               n;
    int               want;
    bit               known;
    while ($fscanf(fd, "%s", tok) == 1) begin
      a = '0;
      b = '0;
      name = '0;
      n = 0;
      want = 0;
      known = 1'b1;
      case (tok)
        "#":      n = $fgets(rest, fd);
        "W", "R": begin
          n = $fscanf(fd, "%h %h", a, b);
          want = 2;
        end
        "P", "E": begin
          n = $fscanf(fd, "%h", a);
          want = 1;
        end
        "I": begin
          n = $fscanf(fd, "%d %d", a, b);
          want = 2;
        end
        "T": begin
          n = $fscanf(fd, "%s", name);
          want = 1;
        end
        "B":      n = 0;
        default: begin
          $display("unknown step code %0s in the stimulus file", tok);
          error_count++;
          known = 1'b0;
        end
      endcase
      if (known && tok != "#") begin
        // a short line would replay as zero values
        if (n != want) begin
          $display("step %0s in the stimulus file is missing its values", tok);
          error_count++;
        end
        step_code.push_back(tok[7:0]);
        step_a.push_back(a);
        step_b.push_back(b);
        step_name.push_back(name);
      end
    end
  endtask

  task automatic finish_test();
    if (test_active) begin
      test_count++;
      if (cur_errors == 0) begin
        $display("test %0s: pass", cur_name);
      end else begin
        $display("test %0s: FAIL with %0d errors", cur_name, cur_errors);
        fail_count++;
      end
    end
  endtask

  task automatic check_data(input logic [7:0] addr, input logic [`SDHC_DW-1:0] expected,
                            input logic [`SDHC_DW-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Error: %0s read 0x%02h expected 0x%04h actual 0x%04h",
               cur_name, addr, expected, actual);
      cur_errors++;
      error_count++;
    end
  endtask

  task automatic check_irq(input logic exp_level, input logic act_level,
                           input int exp_pulses, input int act_pulses);
    check_count++;
    if (act_level !== exp_level) begin
      $display("Error: %0s irq level expected %0b actual %0b", cur_name, exp_level, act_level);
      cur_errors++;
      error_count++;
    end
    if (act_pulses != exp_pulses) begin
      $display("Error: %0s irq pulses expected %0d actual %0d",
               cur_name, exp_pulses, act_pulses);
      cur_errors++;
      error_count++;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
    @(negedge clk);
    wr.strobe = 1'b1;
    wr.addr   = addr;
    wr.data   = data;
    @(negedge clk);
    wr = '0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [`SDHC_DW-1:0] data);
    @(negedge clk);
    rd_addr = sdhc_addr_e'(addr);
    #(CLK_PERIOD / 4);
    data = rdata;
  endtask

  task automatic sample_irq(output logic level, output int pulses);
    @(negedge clk);
    #(CLK_PERIOD / 4);
    level = irq;
    pulses = pulse_total - pulse_mark;
    pulse_mark = pulse_total;
  endtask

  // error and block done inputs are single cycle pulses
  task automatic pulse_inputs(input logic [7:0] errs, input logic done);
    @(negedge clk);
    err_event  = errs;
    block_done = done;
    @(negedge clk);
    err_event  = '0;
    block_done = 1'b0;
  endtask

  task automatic run_steps();
    logic [`SDHC_DW-1:0] rd;
    logic                level;
    int                  pulses;
    for (int i = 0; i < step_code.size(); i++) begin
      case (step_code[i])
        "W": write_reg(step_a[i][7:0], step_b[i][15:0]);
        "R": begin
          read_reg(step_a[i][7:0], rd);
          check_data(step_a[i][7:0], step_b[i][15:0], rd);
        end
        "P": begin
          @(negedge clk);
          present = sdhc_present_t'(step_a[i][4:0]);
        end
        "E": pulse_inputs(step_a[i][7:0], 1'b0);
        "B": pulse_inputs(8'h00, 1'b1);
        "I": begin
          sample_irq(level, pulses);
          check_irq(step_a[i][0], level, int'(step_b[i]), pulses);
        end
        default: begin
          finish_test();
          cur_name    = step_name[i];
          cur_errors  = 0;
          test_active = 1'b1;
        end
      endcase
    end
  endtask

  initial begin
    int fd;
    clk        = 1'b0;
    rst_n      = 1'b0;
    wr         = '0;
    rd_addr    = BLK_SIZE;
    present    = '0;
    err_event  = '0;
    block_done = 1'b0;
    cur_name   = "none";
    fd = $fopen("sdhc_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sdhc_testdata.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      load_steps(fd);
      $fclose(fd);
      if (step_code.size() == 0) begin
        $display("the stimulus file holds no steps");
        error_count++;
      end
      cycle_limit = CYCLES_PER_STEP * step_code.size() + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      run_steps();
      finish_test();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, fail_count, check_count, error_count);
      if (error_count == 0 && fail_count == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

// File: sdhc_sva.sv
`timescale 1ns/1ps
// assertions on the SD host register control
// interrupt pulse width and inhibit gating of register selects

module sdhc_sva import sdhc_pkg::*; (
  input logic          clk_i,
  input logic          rst_n_i,
  input sdhc_present_t present_i,
  input sdhc_wr_sel_t  wr_sel_i,
  input logic          irq_pulse_i
);

  // pulse marks only the first cycle of the level
  a_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_pulse_i |=> !irq_pulse_i)
    else $error("irq pulse held for two cycles");

  a_xfer_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    present_i.cmd_inhibit |-> !wr_sel_i.xfer_mode)
    else $error("transfer mode select while command inhibit is high");

  // size and count both follow the data line
  a_blk_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    present_i.dat_inhibit |-> !(wr_sel_i.blk_size || wr_sel_i.blk_count))
    else $error("block size or count select while data inhibit is high");

endmodule

bind sdhc_reg_logic sdhc_sva u_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .present_i   (present_i),
  .wr_sel_i    (wr_sel_o),
  .irq_pulse_i (irq_pulse_o)
);

// File: sdhc_top.sv
`timescale 1ns/1ps
// SD host register block top level
// control logic, register storage and block counter

`include "sdhc_settings.svh"

module sdhc_top import sdhc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  sdhc_bus_wr_t        wr_i,
  input  sdhc_addr_e          rd_addr_i,
  output logic [`SDHC_DW-1:0] rdata_o,
  input  sdhc_present_t       present_i,
  input  logic [7:0]          err_event_i,
  input  logic                block_done_i,
  output logic                irq_o,
  output logic                irq_pulse_o
);

  sdhc_wr_sel_t        wr_sel;
  sdhc_norm_sts_t      norm_set;
  sdhc_err_t           err_set;
  sdhc_xfer_mode_t     xfer_mode;
  sdhc_norm_sts_t      norm_sts;
  sdhc_err_t           err_sts;
  sdhc_norm_sts_t      norm_sts_en;
  sdhc_err_t           err_sts_en;
  sdhc_norm_sts_t      norm_sig_en;
  sdhc_err_t           err_sig_en;
  logic [`SDHC_DW-1:0] block_count;

  sdhc_reg_logic u_reg_logic (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wr_i          (wr_i),
    .present_i     (present_i),
    .err_event_i   (err_event_i),
    .norm_sts_i    (norm_sts),
    .err_sts_i     (err_sts),
    .norm_sts_en_i (norm_sts_en),
    .err_sts_en_i  (err_sts_en),
    .norm_sig_en_i (norm_sig_en),
    .err_sig_en_i  (err_sig_en),
    .wr_sel_o      (wr_sel),
    .norm_set_o    (norm_set),
    .err_set_o     (err_set),
    .irq_o         (irq_o),
    .irq_pulse_o   (irq_pulse_o)
  );

  sdhc_regs u_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wr_i          (wr_i),
    .wr_sel_i      (wr_sel),
    .norm_set_i    (norm_set),
    .err_set_i     (err_set),
    .present_i     (present_i),
    .block_count_i (block_count),
    .rd_addr_i     (rd_addr_i),
    .rdata_o       (rdata_o),
    .xfer_mode_o   (xfer_mode),
    .norm_sts_o    (norm_sts),
    .err_sts_o     (err_sts),
    .norm_sts_en_o (norm_sts_en),
    .err_sts_en_o  (err_sts_en),
    .norm_sig_en_o (norm_sig_en),
    .err_sig_en_o  (err_sig_en)
  );

  // block count write goes straight to the counter
  sdhc_block_counter u_block_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_i       (wr_sel.blk_count),
    .load_val_i   (wr_i.data),
    .block_done_i (block_done_i),
    .xfer_mode_i  (xfer_mode),
    .count_o      (block_count)
  );

endmodule

// File: sdhc_reg_logic.sv
`timescale 1ns/1ps
// SD host register control
// gates register writes on the inhibit levels, turns present state
// edges and error pulses into status sets, and raises the interrupt

module sdhc_reg_logic import sdhc_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  sdhc_bus_wr_t   wr_i,
  input  sdhc_present_t  present_i,
  input  sdhc_err_t      err_event_i,
  input  sdhc_norm_sts_t norm_sts_i,
  input  sdhc_err_t      err_sts_i,
  input  sdhc_norm_sts_t norm_sts_en_i,
  input  sdhc_err_t      err_sts_en_i,
  input  sdhc_norm_sts_t norm_sig_en_i,
  input  sdhc_err_t      err_sig_en_i,
  output sdhc_wr_sel_t   wr_sel_o,
  output sdhc_norm_sts_t norm_set_o,
  output sdhc_err_t      err_set_o,
  output logic           irq_o,
  output logic           irq_pulse_o
);

  sdhc_wr_sel_t   dec_sel;
  sdhc_present_t  present_q;
  sdhc_norm_sts_t norm_edge;
  logic           norm_irq;
  logic           err_irq;
  logic           irq_q;

  // raw address decode, present state is read only
  always_comb begin
    dec_sel = '0;
    if (wr_i.strobe) begin
      case (wr_i.addr)
        BLK_SIZE:    dec_sel.blk_size    = 1'b1;
        BLK_COUNT:   dec_sel.blk_count   = 1'b1;
        XFER_MODE:   dec_sel.xfer_mode   = 1'b1;
        NORM_STS:    dec_sel.norm_sts    = 1'b1;
        ERR_STS:     dec_sel.err_sts     = 1'b1;
        NORM_STS_EN: dec_sel.norm_sts_en = 1'b1;
        ERR_STS_EN:  dec_sel.err_sts_en  = 1'b1;
        NORM_SIG_EN: dec_sel.norm_sig_en = 1'b1;
        ERR_SIG_EN:  dec_sel.err_sig_en  = 1'b1;
        default:     dec_sel = '0;
      endcase
    end
  end

  always_comb begin
    wr_sel_o = dec_sel;
    // transfer mode frozen while a command is in flight
    if (present_i.cmd_inhibit) begin
      wr_sel_o.xfer_mode = 1'b0;
    end
    // size and count frozen while the data line is busy
    if (present_i.dat_inhibit) begin
      wr_sel_o.blk_size  = 1'b0;
      wr_sel_o.blk_count = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      present_q <= '0;
      irq_q     <= 1'b0;
    end else begin
      present_q <= present_i;
      irq_q     <= irq_o;
    end
  end

  // level changes against last cycle
  always_comb begin
    norm_edge.cmd_complete  = present_q.cmd_inhibit & ~present_i.cmd_inhibit;
    norm_edge.xfer_complete = present_q.dat_inhibit & ~present_i.dat_inhibit;
    norm_edge.buf_wr_ready  = ~present_q.buf_wr_en & present_i.buf_wr_en;
    norm_edge.buf_rd_ready  = ~present_q.buf_rd_en & present_i.buf_rd_en;
    norm_edge.card_ins      = ~present_q.card_inserted & present_i.card_inserted;
    norm_edge.card_rem      = present_q.card_inserted & ~present_i.card_inserted;
  end

  assign norm_set_o = norm_edge & norm_sts_en_i;
  assign err_set_o  = err_event_i & err_sts_en_i;

  // error part stands in for the summary bit
  assign norm_irq    = |(norm_sts_i & norm_sig_en_i);
  assign err_irq     = |(err_sts_i & err_sig_en_i);
  assign irq_o       = norm_irq | err_irq;
  assign irq_pulse_o = irq_o & ~irq_q;

endmodule

// File: sdhc_regs.sv
`timescale 1ns/1ps
// SD host register storage
// holds the writable registers and both status registers, applies
// hardware sets and write-one-to-clear, and drives the read data

`include "sdhc_settings.svh"

module sdhc_regs import sdhc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  sdhc_bus_wr_t        wr_i,
  input  sdhc_wr_sel_t        wr_sel_i,
  input  sdhc_norm_sts_t      norm_set_i,
  input  sdhc_err_t           err_set_i,
  input  sdhc_present_t       present_i,
  input  logic [`SDHC_DW-1:0] block_count_i,
  input  sdhc_addr_e          rd_addr_i,
  output logic [`SDHC_DW-1:0] rdata_o,
  output sdhc_xfer_mode_t     xfer_mode_o,
  output sdhc_norm_sts_t      norm_sts_o,
  output sdhc_err_t           err_sts_o,
  output sdhc_norm_sts_t      norm_sts_en_o,
  output sdhc_err_t           err_sts_en_o,
  output sdhc_norm_sts_t      norm_sig_en_o,
  output sdhc_err_t           err_sig_en_o
);

  // bus layouts of the sparse registers
  function automatic logic [`SDHC_DW-1:0] norm_to_word(sdhc_norm_sts_t n);
    return {8'b0, n.card_rem, n.card_ins, n.buf_rd_ready, n.buf_wr_ready,
            2'b0, n.xfer_complete, n.cmd_complete};
  endfunction

  function automatic sdhc_norm_sts_t word_to_norm(logic [`SDHC_DW-1:0] w);
    return {w[7], w[6], w[5], w[4], w[1], w[0]};
  endfunction

  function automatic logic [`SDHC_DW-1:0] xfer_to_word(sdhc_xfer_mode_t x);
    return {10'b0, x.multi_blk, x.dir_read, 1'b0, x.acmd12_en, x.blk_cnt_en, x.dma_en};
  endfunction

  function automatic sdhc_xfer_mode_t word_to_xfer(logic [`SDHC_DW-1:0] w);
    return {w[5], w[4], w[2], w[1], w[0]};
  endfunction

  function automatic logic [`SDHC_DW-1:0] present_to_word(sdhc_present_t p);
    return {p.card_inserted, 3'b0, p.buf_rd_en, p.buf_wr_en, 8'b0,
            p.dat_inhibit, p.cmd_inhibit};
  endfunction

  function automatic logic [`SDHC_DW-1:0] err_to_word(sdhc_err_t e);
    return {{(`SDHC_DW-8){1'b0}}, e};
  endfunction

  logic [`SDHC_BSW-1:0] blk_size_q;
  sdhc_xfer_mode_t      xfer_mode_q;
  sdhc_norm_sts_t       norm_sts_q;
  sdhc_err_t            err_sts_q;
  sdhc_norm_sts_t       norm_sts_en_q;
  sdhc_err_t            err_sts_en_q;
  sdhc_norm_sts_t       norm_sig_en_q;
  sdhc_err_t            err_sig_en_q;
  sdhc_norm_sts_t       norm_clr;
  sdhc_err_t            err_clr;
  logic                 err_summary;

  // ones written to a status register clear those bits
  assign norm_clr = wr_sel_i.norm_sts ? word_to_norm(wr_i.data) : '0;
  assign err_clr  = wr_sel_i.err_sts ? wr_i.data[7:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      blk_size_q    <= '0;
      xfer_mode_q   <= '0;
      norm_sts_q    <= '0;
      err_sts_q     <= '0;
      norm_sts_en_q <= '0;
      err_sts_en_q  <= '0;
      norm_sig_en_q <= '0;
      err_sig_en_q  <= '0;
    end else begin
      if (wr_sel_i.blk_size) begin
        // dma boundary bits above are dropped
        blk_size_q <= wr_i.data[`SDHC_BSW-1:0];
      end
      if (wr_sel_i.xfer_mode) begin
        xfer_mode_q <= word_to_xfer(wr_i.data);
      end
      if (wr_sel_i.norm_sts_en) begin
        norm_sts_en_q <= word_to_norm(wr_i.data);
      end
      if (wr_sel_i.err_sts_en) begin
        err_sts_en_q <= wr_i.data[7:0];
      end
      if (wr_sel_i.norm_sig_en) begin
        norm_sig_en_q <= word_to_norm(wr_i.data);
      end
      if (wr_sel_i.err_sig_en) begin
        err_sig_en_q <= wr_i.data[7:0];
      end
      // set beats clear in the same cycle
      norm_sts_q <= (norm_sts_q & ~norm_clr) | norm_set_i;
      err_sts_q  <= (err_sts_q & ~err_clr) | err_set_i;
    end
  end

  // error summary is derived, never stored
  assign err_summary = |err_sts_q;

  always_comb begin
    case (rd_addr_i)
      BLK_SIZE:    rdata_o = {{(`SDHC_DW-`SDHC_BSW){1'b0}}, blk_size_q};
      BLK_COUNT:   rdata_o = block_count_i;
      XFER_MODE:   rdata_o = xfer_to_word(xfer_mode_q);
      PRESENT:     rdata_o = present_to_word(present_i);
      NORM_STS:    rdata_o = norm_to_word(norm_sts_q) | {err_summary, {(`SDHC_DW-1){1'b0}}};
      ERR_STS:     rdata_o = err_to_word(err_sts_q);
      NORM_STS_EN: rdata_o = norm_to_word(norm_sts_en_q);
      ERR_STS_EN:  rdata_o = err_to_word(err_sts_en_q);
      NORM_SIG_EN: rdata_o = norm_to_word(norm_sig_en_q);
      ERR_SIG_EN:  rdata_o = err_to_word(err_sig_en_q);
      default:     rdata_o = '0;
    endcase
  end

  assign xfer_mode_o   = xfer_mode_q;
  assign norm_sts_o    = norm_sts_q;
  assign err_sts_o     = err_sts_q;
  assign norm_sts_en_o = norm_sts_en_q;
  assign err_sts_en_o  = err_sts_en_q;
  assign norm_sig_en_o = norm_sig_en_q;
  assign err_sig_en_o  = err_sig_en_q;

endmodule

// File: sdhc_block_counter.sv
`timescale 1ns/1ps
// SD host block counter
// loaded from the register bus, counts down once per finished block

`include "sdhc_settings.svh"

module sdhc_block_counter import sdhc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                load_i,
  input  logic [`SDHC_DW-1:0] load_val_i,
  input  logic                block_done_i,
  input  sdhc_xfer_mode_t     xfer_mode_i,
  output logic [`SDHC_DW-1:0] count_o
);

  logic [`SDHC_DW-1:0] count_q;
  logic                dec;

  // holds at zero, only counts when enabled in transfer mode
  assign dec = block_done_i & xfer_mode_i.blk_cnt_en & (count_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      // software load wins over a block done
      count_q <= load_val_i;
    end else if (dec) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

// File: sdhc_pkg.sv
// SD host register block types
// address map, bus write, present state and status layouts

`include "sdhc_settings.svh"

package sdhc_pkg;

  typedef enum logic [`SDHC_AW-1:0] {
    BLK_SIZE    = 8'h04,
    BLK_COUNT   = 8'h06,
    XFER_MODE   = 8'h0C,
    PRESENT     = 8'h24,
    NORM_STS    = 8'h30,
    ERR_STS     = 8'h32,
    NORM_STS_EN = 8'h34,
    ERR_STS_EN  = 8'h36,
    NORM_SIG_EN = 8'h38,
    ERR_SIG_EN  = 8'h3A
  } sdhc_addr_e;

  typedef struct packed {
    logic                strobe;
    logic [`SDHC_AW-1:0] addr;
    logic [`SDHC_DW-1:0] data;
  } sdhc_bus_wr_t;

  // first field is the msb so cmd_inhibit sits at bit 0
  typedef struct packed {
    logic card_inserted;
    logic buf_rd_en;
    logic buf_wr_en;
    logic dat_inhibit;
    logic cmd_inhibit;
  } sdhc_present_t;

  typedef struct packed {
    logic multi_blk;
    logic dir_read;
    logic acmd12_en;
    logic blk_cnt_en;
    logic dma_en;
  } sdhc_xfer_mode_t;

  typedef struct packed {
    logic card_rem;
    logic card_ins;
    logic buf_rd_ready;
    logic buf_wr_ready;
    logic xfer_complete;
    logic cmd_complete;
  } sdhc_norm_sts_t;

  // bit 7 holds the auto cmd12 error
  typedef logic [7:0] sdhc_err_t;

  typedef struct packed {
    logic blk_size;
    logic blk_count;
    logic xfer_mode;
    logic norm_sts;
    logic err_sts;
    logic norm_sts_en;
    logic err_sts_en;
    logic norm_sig_en;
    logic err_sig_en;
  } sdhc_wr_sel_t;

endpackage

// File: sdhc_settings.svh
// SD host register block widths
// shared by the type package and the datapath modules

`ifndef SDHC_SETTINGS_SVH
`define SDHC_SETTINGS_SVH

// register data bus
`define SDHC_DW 16

// register address
`define SDHC_AW 8

// stored transfer block size, upper bits of the register are not kept
`define SDHC_BSW 12

`endif
